/* build.f */
source/fan_pkg.sv
source/fan_vn_capture.sv
source/fan_level_decode.sv
source/fan_skew_align.sv
source/fan_ctrl.sv
bench/fan_ctrl_checker.sv
bench/fan_ctrl_tb.sv

/* Makefile */
SIM = obj_dir/fan_ctrl_sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -f build.f --top-module fan_ctrl_tb -Mdir obj_dir -o fan_ctrl_sim
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

/* bench/fan_ctrl_tb.sv */
//##################################################
// FAN controller testbench
// xorshift VN segment stimulus, mid-stream reset and
// a drain at the end, checked by the checker module
//##################################################

`timescale 1ns/1ps

module fan_ctrl_tb;

	localparam int NUM_PES = 32;
	localparam int LOG2_PES = $clog2(NUM_PES);
	localparam int SEL_W = $clog2(LOG2_PES);
	localparam int NUM_SEL_ADDERS = NUM_PES/4 - 1;
	localparam int RAND_CYCLES = 400;

	logic                                   CLK;
	logic                                   rst;
	logic [NUM_PES-1:0][LOG2_PES-1:0]       i_vn;
	logic                                   i_stationary;
	logic                                   i_data_valid;
	fan_pkg::fan_node_ctrl_t [NUM_PES-2:0]   o_node_ctrl;
	logic [NUM_SEL_ADDERS-1:0][2*SEL_W-1:0] o_reduction_sel;
	logic                                   o_reduction_valid;

	logic [31:0] rng;
	int          errors;
	int          checks;
	int          timeouts;

	fan_ctrl #(
		.NUM_PES(NUM_PES)
	) uut (
		.CLK              (CLK),
		.rst              (rst),
		.i_vn             (i_vn),
		.i_stationary     (i_stationary),
		.i_data_valid     (i_data_valid),
		.o_node_ctrl      (o_node_ctrl),
		.o_reduction_sel  (o_reduction_sel),
		.o_reduction_valid(o_reduction_valid)
	);

	fan_ctrl_checker #(
		.NUM_PES(NUM_PES)
	) u_checker (
		.CLK              (CLK),
		.rst              (rst),
		.i_vn             (i_vn),
		.i_stationary     (i_stationary),
		.i_data_valid     (i_data_valid),
		.i_node_ctrl      (o_node_ctrl),
		.i_reduction_sel  (o_reduction_sel),
		.i_reduction_valid(o_reduction_valid),
		.o_errors         (errors),
		.o_checks         (checks)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	//##################################################
	// VN patterns
	//##################################################

	// mode 0 one vn everywhere, 1 one vn per leaf, else segments
	task automatic fill_pattern(input int mode);
		int pos;
		int len;
		logic [LOG2_PES-1:0] id;
		rng = xorshift(rng);
		id = rng[LOG2_PES-1:0];
		pos = 0;
		if (mode == 0) begin
			for (int i = 0; i < NUM_PES; i++) i_vn[i] = id;
		end else if (mode == 1) begin
			for (int i = 0; i < NUM_PES; i++) i_vn[i] = LOG2_PES'(i);
		end else begin
			while (pos < NUM_PES) begin
				rng = xorshift(rng);
				len = 1 + int'(rng[7:0]) % 12; // 1 to 12 leaves
				for (int i = 0; i < len && pos < NUM_PES; i++) begin
					i_vn[pos] = id;
					pos++;
				end
				id = id + LOG2_PES'(1); // wraps
			end
		end
	endtask

	task automatic drive_directed(input int mode, input int n);
		repeat (n) begin
			@(negedge CLK);
			i_data_valid = 1'b1;
			i_stationary = 1'b0;
			fill_pattern(mode);
		end
	endtask

	task automatic drive_random_cycle();
		logic [3:0] pick;
		@(negedge CLK);
		rng = xorshift(rng);
		i_data_valid = (rng[3:0] != 4'd0);
		i_stationary = (rng[7:5] == 3'd0);
		pick = rng[11:8];
		if (pick == 4'd0) fill_pattern(0);
		else if (pick == 4'd1) fill_pattern(1);
		else fill_pattern(2);
	endtask

	function automatic bit outputs_idle();
		return o_reduction_valid == 1'b0 && o_node_ctrl == '0 && o_reduction_sel == '0;
	endfunction

	task automatic wait_for_valid(input int limit);
		int n;
		n = 0;
		while (o_reduction_valid !== 1'b1 && n < limit) begin
			@(negedge CLK);
			n++;
		end
		if (o_reduction_valid !== 1'b1) begin
			$display("timeout: reduction valid did not rise within %0d cycles", limit);
			timeouts++;
		end
	endtask

	task automatic wait_for_drain(input int limit);
		int n;
		n = 0;
		while (!outputs_idle() && n < limit) begin
			@(negedge CLK);
			n++;
		end
		if (!outputs_idle()) begin
			$display("timeout: outputs still active %0d cycles after the stream stopped", limit);
			timeouts++;
		end
	endtask

	//##################################################
	// test sequence
	//##################################################

	initial begin
		rst          = 1'b1;
		i_vn         = '0;
		i_stationary = 1'b0;
		i_data_valid = 1'b0;
		rng          = 32'he427;
		timeouts     = 0;

		repeat (8) @(negedge CLK);
		rst = 1'b0;

		drive_directed(0, 4); // all leaves one vn
		drive_directed(1, 4); // every leaf its own vn
		drive_directed(2, 4);
		wait_for_valid(20);

		repeat (RAND_CYCLES) drive_random_cycle();

		// reset in the middle of a stream
		drive_random_cycle();
		rst = 1'b1;
		drive_random_cycle();
		drive_random_cycle();
		rst = 1'b0;
		drive_directed(2, 1); // streaming data held until valid returns
		wait_for_valid(20);
		repeat (150) drive_random_cycle();

		@(negedge CLK);
		i_data_valid = 1'b0;
		i_stationary = 1'b0;
		wait_for_drain(40);
		repeat (2) @(negedge CLK);

		$display("checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0 && checks > 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* bench/fan_ctrl_checker.sv */
//##################################################
// FAN controller checker
// reference model of the decode rules and pipeline
// latencies, compared against every DUT output
//##################################################

`timescale 1ns/1ps

module fan_ctrl_checker #(
	parameter int NUM_PES = 32,
	localparam int LOG2_PES = $clog2(NUM_PES),
	localparam int SEL_W = $clog2(LOG2_PES),
	localparam int NUM_SEL_ADDERS = NUM_PES/4 - 1
) (
	input  logic                                    CLK,
	input  logic                                    rst,
	input  logic [NUM_PES-1:0][LOG2_PES-1:0]        i_vn,
	input  logic                                    i_stationary,
	input  logic                                    i_data_valid,
	input  fan_pkg::fan_node_ctrl_t [NUM_PES-2:0]    i_node_ctrl,
	input  logic [NUM_SEL_ADDERS-1:0][2*SEL_W-1:0]  i_reduction_sel,
	input  logic                                    i_reduction_valid,
	output int                                      o_errors,
	output int                                      o_checks
);

	localparam int DEPTH = 16; // longer than the deepest level latency

	typedef logic [NUM_PES-1:0][LOG2_PES-1:0] vn_t;

	vn_t  hist_vn [DEPTH];
	logic hist_stream [DEPTH]; // valid and not stationary
	int   tick_n = 0;
	int   last_rst = -1;       // last edge that sampled reset
	bit   seen_rst = 1'b0;
	int   errors = 0;
	int   checks = 0;

	assign o_errors = errors;
	assign o_checks = checks;

	// leaves off either end of the tree belong to no vn
	function automatic bit same_leaf(vn_t vn, int i, int j);
		if (i < 0 || j < 0 || i >= NUM_PES || j >= NUM_PES) begin
			return 1'b0;
		end
		return vn[i] == vn[j];
	endfunction

	// input of edge src still in flight, not flushed by reset
	function automatic bit stream_at(int src);
		if (src < 0 || src <= last_rst) begin
			return 1'b0;
		end
		return hist_stream[src % DEPTH];
	endfunction

	function automatic fan_pkg::fan_node_ctrl_t model_ctrl(vn_t vn, int lvl, int x);
		int s;
		int h;
		int a;
		int b;
		bit ld;
		bit rd;
		fan_pkg::fan_node_ctrl_t c;
		s = 1 << (lvl + 1);
		h = 1 << lvl;
		a = x*s + h - 1;
		b = a + 1;
		c.add_en = same_leaf(vn, a, b);
		if (lvl == 0) begin
			ld = same_leaf(vn, a, a - 1);
			rd = same_leaf(vn, b, b + 1);
			if (c.add_en) c.cmd = fan_pkg::CMD_BYPASS;
			else if (!ld && !rd) c.cmd = fan_pkg::CMD_BOTH_DONE;
			else if (ld && !rd) c.cmd = fan_pkg::CMD_RIGHT_DONE;
			else if (rd && !ld) c.cmd = fan_pkg::CMD_LEFT_DONE;
			else c.cmd = fan_pkg::CMD_BYPASS;
		end else begin
			ld = same_leaf(vn, x*s + h/2 - 1, x*s + h/2) && !same_leaf(vn, x*s + h/2, b)
				&& !same_leaf(vn, x*s + h/2 - 1, x*s - 1);
			rd = same_leaf(vn, b + h/2 - 1, b + h/2) && !same_leaf(vn, b + h/2 - 1, a)
				&& !same_leaf(vn, b + h/2, (x + 1)*s);
			if (ld && rd) c.cmd = fan_pkg::CMD_BOTH_DONE;
			else if (rd) c.cmd = fan_pkg::CMD_RIGHT_DONE;
			else if (ld) c.cmd = fan_pkg::CMD_LEFT_DONE;
			else c.cmd = fan_pkg::CMD_IDLE;
		end
		return c;
	endfunction

	function automatic logic [2*SEL_W-1:0] model_sel(vn_t vn, int lvl, int x);
		int a;
		int b;
		bit found_l;
		bit found_r;
		logic [SEL_W-1:0] sl;
		logic [SEL_W-1:0] sr;
		a = x*(1 << (lvl + 1)) + (1 << lvl) - 1;
		b = a + 1;
		found_l = 1'b0;
		found_r = 1'b0;
		sl = SEL_W'(lvl - 1); // no match
		sr = '0;
		for (int k = 0; k <= lvl - 2; k++) begin
			if (!found_l && same_leaf(vn, a, a - (1 << (lvl - 1 - k)))) begin
				sl = SEL_W'(k);
				found_l = 1'b1;
			end
			if (!found_r && same_leaf(vn, b, b + (1 << (lvl - 1 - k)))) begin
				sr = SEL_W'(lvl - 1 - k);
				found_r = 1'b1;
			end
		end
		return {sr, sl};
	endfunction

	task automatic report_fail(string name, int lvl, int x, logic [31:0] exp_val,
			logic [31:0] act_val);
		errors++;
		$display("[FAIL] %s L%0d adder %0d: expected %0h, actual %0h",
			name, lvl, x, exp_val, act_val);
	endtask

	//##################################################
	// per-edge comparison, pre-edge output values
	//##################################################

	always @(posedge CLK) begin : compare
		int idx;
		int sidx;
		int src;
		fan_pkg::fan_node_ctrl_t exp_c;
		logic [2*SEL_W-1:0] exp_s;
		if (seen_rst) begin
			checks++;
			if (i_reduction_valid !== stream_at(tick_n - 4)) begin
				report_fail("reduction_valid", 0, 0, 32'(stream_at(tick_n - 4)),
					32'(i_reduction_valid));
			end
			idx = 0;
			sidx = 0;
			for (int lvl = 0; lvl < LOG2_PES; lvl++) begin
				src = tick_n - 4 - lvl; // level L lags by L more cycles
				for (int x = 0; x < (NUM_PES >> (lvl + 1)); x++) begin
					exp_c = '0;
					exp_s = '0;
					if (stream_at(src)) begin
						exp_c = model_ctrl(hist_vn[src % DEPTH], lvl, x);
						if (lvl >= 2) exp_s = model_sel(hist_vn[src % DEPTH], lvl, x);
					end
					checks++;
					if (i_node_ctrl[idx].add_en !== exp_c.add_en) begin
						report_fail("add_en", lvl, x, 32'(exp_c.add_en),
							32'(i_node_ctrl[idx].add_en));
					end
					if (i_node_ctrl[idx].cmd !== exp_c.cmd) begin
						report_fail(lvl == 0 ? "level0_cmd" : "tree_cmd", lvl, x,
							32'(exp_c.cmd), 32'(i_node_ctrl[idx].cmd));
					end
					if (lvl >= 2) begin
						if (i_reduction_sel[sidx] !== exp_s) begin
							report_fail("select", lvl, x, 32'(exp_s), 32'(i_reduction_sel[sidx]));
						end
						sidx++;
					end
					idx++;
				end
			end
		end
		hist_vn[tick_n % DEPTH]     = i_vn;
		hist_stream[tick_n % DEPTH] = i_data_valid & ~i_stationary;
		if (rst) begin
			last_rst = tick_n;
			seen_rst = 1'b1;
		end
		tick_n++;
	end

endmodule

/* source/fan_ctrl.sv */
//##################################################
// FAN controller top level
// VN capture, one decoder per tree level and the
// skew alignment towards the adder tree
//##################################################

`timescale 1ns/1ps

module fan_ctrl #(
	parameter int NUM_PES = 32,
	localparam int LOG2_PES = $clog2(NUM_PES),
	localparam int SEL_W = $clog2(LOG2_PES),
	localparam int NUM_SEL_ADDERS = NUM_PES/4 - 1
) (
	input  logic                                    CLK,
	input  logic                                    rst,
	input  logic [NUM_PES-1:0][LOG2_PES-1:0]        i_vn,
	input  logic                                    i_stationary, // stationary load, no reduction
	input  logic                                    i_data_valid,
	output fan_pkg::fan_node_ctrl_t [NUM_PES-2:0]    o_node_ctrl,
	output logic [NUM_SEL_ADDERS-1:0][2*SEL_W-1:0]  o_reduction_sel,
	output logic                                    o_reduction_valid
);

	logic [NUM_PES-1:0][LOG2_PES-1:0]       w_vn;
	logic                                   w_decode_valid;
	fan_pkg::fan_node_ctrl_t [NUM_PES-2:0]   w_ctrl; // level ordered, level 0 first
	logic [NUM_SEL_ADDERS-1:0][2*SEL_W-1:0] w_sel;  // levels 2 and up only

	fan_vn_capture #(
		.NUM_PES(NUM_PES)
	) u_capture (
		.CLK           (CLK),
		.rst           (rst),
		.i_vn          (i_vn),
		.i_stationary  (i_stationary),
		.i_data_valid  (i_data_valid),
		.o_vn          (w_vn),
		.o_decode_valid(w_decode_valid)
	);

	//##################################################
	// per-level decoders
	//##################################################

	for (genvar l = 0; l < LOG2_PES; l++) begin : g_dec
		localparam int CNT = NUM_PES >> (l + 1);
		localparam int BASE = NUM_PES - (NUM_PES >> l);

		if (l >= 2) begin : g_with_sel
			localparam int SBASE = NUM_PES/4 - (NUM_PES >> l);

			fan_level_decode #(
				.NUM_PES(NUM_PES),
				.LVL    (l)
			) u_dec (
				.i_vn          (w_vn),
				.i_decode_valid(w_decode_valid),
				.o_ctrl        (w_ctrl[BASE +: CNT]),
				.o_sel         (w_sel[SBASE +: CNT])
			);
		end else begin : g_no_sel
			fan_level_decode #(
				.NUM_PES(NUM_PES),
				.LVL    (l)
			) u_dec (
				.i_vn          (w_vn),
				.i_decode_valid(w_decode_valid),
				.o_ctrl        (w_ctrl[BASE +: CNT]),
				.o_sel         ()
			);
		end
	end

	fan_skew_align #(
		.NUM_PES(NUM_PES)
	) u_align (
		.CLK              (CLK),
		.rst              (rst),
		.i_ctrl           (w_ctrl),
		.i_sel            (w_sel),
		.i_decode_valid   (w_decode_valid),
		.o_node_ctrl      (o_node_ctrl),
		.o_reduction_sel  (o_reduction_sel),
		.o_reduction_valid(o_reduction_valid)
	);

endmodule

/* source/fan_skew_align.sv */
//##################################################
// FAN skew alignment
// delays level L controls by L+1 cycles so they meet
// partial sums climbing the tree, then registers all
//##################################################

`timescale 1ns/1ps

module fan_skew_align #(
	parameter int NUM_PES = 32,
	localparam int LOG2_PES = $clog2(NUM_PES),
	localparam int SEL_W = $clog2(LOG2_PES),
	localparam int NUM_SEL_ADDERS = NUM_PES/4 - 1
) (
	input  logic                                     CLK,
	input  logic                                     rst,
	input  fan_pkg::fan_node_ctrl_t [NUM_PES-2:0]     i_ctrl,
	input  logic [NUM_SEL_ADDERS-1:0][2*SEL_W-1:0]   i_sel,
	input  logic                                     i_decode_valid,
	output fan_pkg::fan_node_ctrl_t [NUM_PES-2:0]     o_node_ctrl,
	output logic [NUM_SEL_ADDERS-1:0][2*SEL_W-1:0]   o_reduction_sel,
	output logic                                     o_reduction_valid
);

	fan_pkg::fan_node_ctrl_t [NUM_PES-2:0]   w_ctrl_tail; // chain ends, all levels
	logic [NUM_SEL_ADDERS-1:0][2*SEL_W-1:0] w_sel_tail;
	logic                                   r_valid_d;

	//##################################################
	// diagonal delay chains
	//##################################################

	for (genvar l = 0; l < LOG2_PES; l++) begin : g_lvl
		localparam int CNT = NUM_PES >> (l + 1);       // adders in this level
		localparam int BASE = NUM_PES - (NUM_PES >> l); // first adder index

		fan_pkg::fan_node_ctrl_t [l:0][CNT-1:0] r_ctrl_pipe;

		always_ff @(posedge CLK) begin
			if (rst) begin
				r_ctrl_pipe <= '0;
			end else begin
				r_ctrl_pipe[0] <= i_ctrl[BASE +: CNT];
				for (int d = 1; d <= l; d++) begin
					r_ctrl_pipe[d] <= r_ctrl_pipe[d-1];
				end
			end
		end

		assign w_ctrl_tail[BASE +: CNT] = r_ctrl_pipe[l];

		if (l >= 2) begin : g_sel
			localparam int SBASE = NUM_PES/4 - (NUM_PES >> l); // first select pair

			logic [l:0][CNT-1:0][2*SEL_W-1:0] r_sel_pipe;

			always_ff @(posedge CLK) begin
				if (rst) begin
					r_sel_pipe <= '0;
				end else begin
					r_sel_pipe[0] <= i_sel[SBASE +: CNT];
					for (int d = 1; d <= l; d++) begin
						r_sel_pipe[d] <= r_sel_pipe[d-1];
					end
				end
			end

			assign w_sel_tail[SBASE +: CNT] = r_sel_pipe[l];
		end
	end

	// valid tracks level 0, one flop deep
	always_ff @(posedge CLK) begin
		if (rst) begin
			r_valid_d <= 1'b0;
		end else begin
			r_valid_d <= i_decode_valid;
		end
	end

	//##################################################
	// output register
	//##################################################

	always_ff @(posedge CLK) begin
		if (rst) begin
			o_node_ctrl       <= '0;
			o_reduction_sel   <= '0;
			o_reduction_valid <= 1'b0;
		end else begin
			o_node_ctrl       <= w_ctrl_tail;
			o_reduction_sel   <= w_sel_tail;
			o_reduction_valid <= r_valid_d;
		end
	end

endmodule

/* source/fan_level_decode.sv */
//##################################################
// FAN level decoder
// add enable, VN completion command and forwarding
// link selects for every adder of one tree level
//##################################################

`timescale 1ns/1ps

module fan_level_decode #(
	parameter int NUM_PES = 32,
	parameter int LVL = 0,
	localparam int LOG2_PES = $clog2(NUM_PES),
	localparam int SEL_W = $clog2(LOG2_PES),
	localparam int NUM_ADDERS = NUM_PES >> (LVL + 1),
	localparam int SEL_ROWS = (LVL >= 2) ? NUM_ADDERS : 1
) (
	input  logic [NUM_PES-1:0][LOG2_PES-1:0]       i_vn,
	input  logic                                    i_decode_valid,
	output fan_pkg::fan_node_ctrl_t [NUM_ADDERS-1:0] o_ctrl,
	output logic [SEL_ROWS-1:0][2*SEL_W-1:0]       o_sel
);

	localparam int S = 2 ** (LVL + 1); // leaves under one adder
	localparam int H = 2 ** LVL;       // leaves under one input

	// leaves outside the tree never share a vn
	function automatic logic same_vn(
		input logic [NUM_PES-1:0][LOG2_PES-1:0] vn,
		input int                               i,
		input int                               j
	);
		if (i < 0 || j < 0 || i >= NUM_PES || j >= NUM_PES) begin
			return 1'b0;
		end
		return vn[i] == vn[j];
	endfunction

	for (genvar x = 0; x < NUM_ADDERS; x++) begin : g_adder
		localparam int A = x*S + H - 1; // last leaf of left subtree
		localparam int B = x*S + H;     // first leaf of right subtree

		logic               add_en;
		fan_pkg::fan_cmd_e  cmd;

		assign add_en = same_vn(i_vn, A, B);

		//##################################################
		// completion command
		//##################################################

		if (LVL == 0) begin : g_leaf_cmd
			logic lc;
			logic rc;

			assign lc = same_vn(i_vn, A, A - 1); // left leaf continues leftward
			assign rc = same_vn(i_vn, B, B + 1); // right leaf continues rightward

			always_comb begin
				if (add_en) begin
					cmd = fan_pkg::CMD_BYPASS;
				end else if (!lc && !rc) begin
					cmd = fan_pkg::CMD_BOTH_DONE;
				end else if (lc && !rc) begin
					cmd = fan_pkg::CMD_RIGHT_DONE;
				end else if (rc && !lc) begin
					cmd = fan_pkg::CMD_LEFT_DONE;
				end else begin
					cmd = fan_pkg::CMD_BYPASS;
				end
			end
		end else begin : g_tree_cmd
			// midpoints of the left and right subtrees
			localparam int P = x*S + H/2 - 1;
			localparam int Q = P + 1;
			localparam int R = B + H/2 - 1;
			localparam int T = R + 1;

			logic l_done;
			logic r_done;

			// vn spans the left child but stops inside this subtree
			assign l_done = same_vn(i_vn, P, Q) && !same_vn(i_vn, Q, B)
				&& !same_vn(i_vn, P, x*S - 1);
			assign r_done = same_vn(i_vn, R, T) && !same_vn(i_vn, R, A)
				&& !same_vn(i_vn, T, (x + 1)*S);

			always_comb begin
				case ({l_done, r_done})
					2'b11:   cmd = fan_pkg::CMD_BOTH_DONE;
					2'b01:   cmd = fan_pkg::CMD_RIGHT_DONE;
					2'b10:   cmd = fan_pkg::CMD_LEFT_DONE;
					default: cmd = fan_pkg::CMD_IDLE;
				endcase
			end
		end

		assign o_ctrl[x].add_en = i_decode_valid & add_en;
		assign o_ctrl[x].cmd    = i_decode_valid ? cmd : fan_pkg::CMD_IDLE;

		//##################################################
		// forwarding link selects
		//##################################################

		if (LVL >= 2) begin : g_sel
			logic [SEL_W-1:0] sel_l;
			logic [SEL_W-1:0] sel_r;

			// walk from the nearest link outward so the farthest match wins
			always_comb begin
				sel_l = SEL_W'(LVL - 1);
				sel_r = '0;
				for (int k = LVL - 2; k >= 0; k--) begin
					if (same_vn(i_vn, A, A - (1 << (LVL - 1 - k)))) begin
						sel_l = SEL_W'(k);
					end
					if (same_vn(i_vn, B, B + (1 << (LVL - 1 - k)))) begin
						sel_r = SEL_W'(LVL - 1 - k);
					end
				end
			end

			assign o_sel[x] = i_decode_valid ? {sel_r, sel_l} : '0; // left in low bits
		end
	end

	// levels 0 and 1 have no forwarding links
	if (LVL < 2) begin : g_no_sel
		assign o_sel = '0;
	end

endmodule

/* source/fan_vn_capture.sv */
//##################################################
// FAN VN capture
// two register stages for the leaf VN ids, plus the
// valid chain that qualifies streaming data
//##################################################

`timescale 1ns/1ps

module fan_vn_capture #(
	parameter int NUM_PES = 32,
	localparam int LOG2_PES = $clog2(NUM_PES)
) (
	input  logic                              CLK,
	input  logic                              rst,
	input  logic [NUM_PES-1:0][LOG2_PES-1:0] i_vn,
	input  logic                              i_stationary,
	input  logic                              i_data_valid,
	output logic [NUM_PES-1:0][LOG2_PES-1:0] o_vn,
	output logic                              o_decode_valid
);

	logic [NUM_PES-1:0][LOG2_PES-1:0] r_vn_s0; // first stage
	logic [NUM_PES-1:0][LOG2_PES-1:0] r_vn_s1; // second stage, feeds decoders
	logic [1:0]                       r_valid;

	// only streaming data is reduced, stationary loads are not
	always_ff @(posedge CLK) begin
		if (rst) begin
			r_valid <= '0;
		end else begin
			r_valid[0] <= i_data_valid & ~i_stationary;
			r_valid[1] <= r_valid[0];
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			r_vn_s0 <= '0;
			r_vn_s1 <= '0;
		end else begin
			r_vn_s0 <= i_vn;
			r_vn_s1 <= r_vn_s0;
		end
	end

	assign o_vn           = r_vn_s1;
	assign o_decode_valid = r_valid[1];

endmodule

/* source/fan_pkg.sv */
//##################################################
// FAN controller shared types
// adder command encoding and the per-adder control word
//##################################################

package fan_pkg;

	// width of the adder command field
	localparam int CMD_W = 3;

	//##################################################
	// adder commands
	//##################################################

	typedef enum logic [CMD_W-1:0] {
		CMD_IDLE       = 3'd0, // nothing to do this cycle
		CMD_BYPASS     = 3'd1, // pass partial sums upward
		CMD_LEFT_DONE  = 3'd3, // left vn complete
		CMD_RIGHT_DONE = 3'd4, // right vn complete
		CMD_BOTH_DONE  = 3'd5  // both vns complete
	} fan_cmd_e;

	//##################################################
	// control word for one adder of the tree
	//##################################################

	typedef struct packed {
		logic     add_en; // add left and right inputs
		fan_cmd_e cmd;
	} fan_node_ctrl_t;

endpackage
